//--- rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // only the opcodes this core executes
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0]  funct7;
        rv32i_reg    rs2;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        rv32i_opcode opcode;
    } r_type;

    typedef struct packed {
        logic [11:0] imm;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        rv32i_opcode opcode;
    } i_type;

    typedef struct packed {
        logic [6:0]  imm_hi;
        rv32i_reg    rs2;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        rv32i_opcode opcode;
    } s_type;

    typedef struct packed {
        logic        imm12;
        logic [5:0]  imm10_5;
        rv32i_reg    rs2;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm4_1;
        logic        imm11;
        rv32i_opcode opcode;
    } b_type;

    typedef struct packed {
        logic [19:0] imm;
        rv32i_reg    rd;
        rv32i_opcode opcode;
    } u_type;

    typedef struct packed {
        logic        imm20;
        logic [9:0]  imm10_1;
        logic        imm11;
        logic [7:0]  imm19_12;
        rv32i_reg    rd;
        rv32i_opcode opcode;
    } j_type;

    typedef union packed {
        r_type r;
        i_type i;
        s_type s;
        b_type b;
        u_type u;
        j_type j;
    } instr_u;

    typedef enum logic [2:0] {
        f3_add  = 3'b000,  // add, addi, sub
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_sr   = 3'b101,  // srl or sra by funct7
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } arith_funct3;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3;

endpackage

//--- ctrl_pkg.sv
package ctrl_pkg;

    localparam logic [31:0] RESET_PC = 32'h0;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    // values match the branch funct3 field
    typedef enum logic [2:0] {
        cmp_eq  = 3'b000,
        cmp_ne  = 3'b001,
        cmp_lt  = 3'b100,
        cmp_ge  = 3'b101,
        cmp_ltu = 3'b110,
        cmp_geu = 3'b111
    } cmp_op_e;

    typedef enum logic {am1_rs1, am1_pc} alumux1_e;
    typedef enum logic {am2_rs2, am2_imm} alumux2_e;

    typedef enum logic [2:0] {
        wb_alu,
        wb_load,
        wb_pc4,
        wb_uimm,
        wb_cmp   // slt family
    } wbmux_e;

    typedef enum logic [1:0] {
        pc_plus4,
        pc_branch,
        pc_jal,
        pc_jalr
    } pcsel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        cmp_op_e    cmp_op;
        alumux1_e   alumux1;
        alumux2_e   alumux2;
        wbmux_e     wbmux;
        pcsel_e     pcsel;
        logic       load;
        logic       store;
        logic       reg_write;
        logic [2:0] funct3;    // memory access width
    } control_word;

endpackage

//--- stage_if.sv
interface id_ex_if import rv32i_pkg::*, ctrl_pkg::*; ();
    logic        valid;
    control_word cw;
    rv32i_word   pc;
    rv32i_word   rs1_data;
    rv32i_word   rs2_data;
    rv32i_word   imm;
    rv32i_reg    rd;

    modport master (output valid, cw, pc, rs1_data, rs2_data, imm, rd);
    modport slave  (input  valid, cw, pc, rs1_data, rs2_data, imm, rd);
endinterface

interface ex_mem_if import rv32i_pkg::*, ctrl_pkg::*; ();
    logic        valid;
    control_word cw;
    rv32i_word   pc_plus4;
    rv32i_word   alu_out;
    logic        br_en;
    rv32i_word   rs2_data;  // store data
    rv32i_reg    rd;

    modport master (output valid, cw, pc_plus4, alu_out, br_en, rs2_data, rd);
    modport slave  (input  valid, cw, pc_plus4, alu_out, br_en, rs2_data, rd);
endinterface

interface mem_wb_if import rv32i_pkg::*, ctrl_pkg::*; ();
    logic        valid;
    control_word cw;
    rv32i_word   pc_plus4;
    rv32i_word   alu_out;
    logic        br_en;
    rv32i_reg    rd;
    logic [1:0]  addr_lo;   // byte offset for load extraction

    modport master (output valid, cw, pc_plus4, alu_out, br_en, rd, addr_lo);
    modport slave  (input  valid, cw, pc_plus4, alu_out, br_en, rd, addr_lo);
endinterface

//--- fetch_stage.sv
module fetch_stage import rv32i_pkg::*, ctrl_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  logic      i_redirect,
    input  rv32i_word i_target,
    output rv32i_word o_pc,
    output rv32i_word o_imem_addr,
    output logic      o_imem_read
);

    rv32i_word pc_q;
    rv32i_word pc_d_q;  // address of the word now returning

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q   <= RESET_PC;
            pc_d_q <= RESET_PC;
        end else begin
            pc_d_q <= pc_q;
            if (i_redirect) begin
                pc_q <= i_target;  // taken branch or jump from execute
            end else begin
                pc_q <= pc_q + 32'd4;
            end
        end
    end

    assign o_pc        = pc_d_q;
    assign o_imem_addr = pc_q;
    assign o_imem_read = 1'b1;  // no stalls, a fetch every cycle

endmodule

//--- decode_stage.sv
module decode_stage import rv32i_pkg::*, ctrl_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    input  rv32i_word i_instr,
    input  rv32i_word i_pc,
    input  logic      i_flush,
    input  logic      i_wb_we,
    input  rv32i_reg  i_wb_rd,
    input  rv32i_word i_wb_data,
    id_ex_if.master   id_ex
);

    instr_u      ir;
    control_word cw;
    rv32i_word   imm;
    logic        known;
    logic        is_reg;
    logic        alt;           // funct7[5], sub and sra
    logic        ifid_valid_q;  // word arriving from imem is live
    rv32i_word   rs1_data;
    rv32i_word   rs2_data;
    rv32i_word   regs [32];

    assign ir     = i_instr;
    assign is_reg = (ir.r.opcode == op_reg);
    assign alt    = ir.r.funct7[5];

    always_comb begin
        cw    = '0;
        imm   = '0;
        known = 1'b1;
        case (ir.r.opcode)
            op_lui: begin
                cw.wbmux     = wb_uimm;
                cw.reg_write = 1'b1;
                imm          = {ir.u.imm, 12'h000};
            end
            op_auipc: begin
                cw.alumux1   = am1_pc;
                cw.alumux2   = am2_imm;
                cw.reg_write = 1'b1;
                imm          = {ir.u.imm, 12'h000};
            end
            op_jal: begin
                cw.pcsel     = pc_jal;
                cw.wbmux     = wb_pc4;
                cw.reg_write = 1'b1;
                imm = {{11{ir.j.imm20}}, ir.j.imm20, ir.j.imm19_12, ir.j.imm11,
                       ir.j.imm10_1, 1'b0};
            end
            op_jalr: begin
                cw.pcsel     = pc_jalr;
                cw.alumux2   = am2_imm;  // rs1 + imm
                cw.wbmux     = wb_pc4;
                cw.reg_write = 1'b1;
                imm          = {{20{ir.i.imm[11]}}, ir.i.imm};
            end
            op_br: begin
                cw.pcsel  = pc_branch;
                cw.cmp_op = cmp_op_e'(ir.b.funct3);
                imm = {{19{ir.b.imm12}}, ir.b.imm12, ir.b.imm11, ir.b.imm10_5,
                       ir.b.imm4_1, 1'b0};
            end
            op_load: begin
                cw.load      = 1'b1;
                cw.alumux2   = am2_imm;
                cw.wbmux     = wb_load;
                cw.reg_write = 1'b1;
                cw.funct3    = ir.i.funct3;
                imm          = {{20{ir.i.imm[11]}}, ir.i.imm};
            end
            op_store: begin
                cw.store   = 1'b1;
                cw.alumux2 = am2_imm;
                cw.funct3  = ir.s.funct3;
                imm        = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
            end
            op_imm, op_reg: begin
                cw.reg_write = 1'b1;
                imm          = {{20{ir.i.imm[11]}}, ir.i.imm};
                if (!is_reg) begin
                    cw.alumux2 = am2_imm;
                end
                case (arith_funct3'(ir.r.funct3))
                    f3_add: begin
                        if (is_reg && alt) begin
                            cw.alu_op = alu_sub;
                        end
                    end
                    f3_sll: cw.alu_op = alu_sll;
                    f3_slt: begin
                        cw.wbmux  = wb_cmp;  // result from the comparator
                        cw.cmp_op = cmp_lt;
                    end
                    f3_sltu: begin
                        cw.wbmux  = wb_cmp;
                        cw.cmp_op = cmp_ltu;
                    end
                    f3_xor: cw.alu_op = alu_xor;
                    f3_sr: begin
                        if (alt) begin
                            cw.alu_op = alu_sra;
                        end else begin
                            cw.alu_op = alu_srl;
                        end
                    end
                    f3_or:  cw.alu_op = alu_or;
                    default: cw.alu_op = alu_and;
                endcase
            end
            default: known = 1'b0;
        endcase
    end

    // register file, write-through from writeback
    always_comb begin
        rs1_data = regs[ir.r.rs1];
        rs2_data = regs[ir.r.rs2];
        if (i_wb_we && i_wb_rd == ir.r.rs1) begin
            rs1_data = i_wb_data;
        end
        if (i_wb_we && i_wb_rd == ir.r.rs2) begin
            rs2_data = i_wb_data;
        end
        if (ir.r.rs1 == '0) begin
            rs1_data = '0;  // x0
        end
        if (ir.r.rs2 == '0) begin
            rs2_data = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_wb_we) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ifid_valid_q <= 1'b0;
            id_ex.valid  <= 1'b0;
        end else begin
            ifid_valid_q <= !i_flush;
            id_ex.valid  <= ifid_valid_q && known && !i_flush;
        end
    end

    always_ff @(posedge clk) begin
        id_ex.cw       <= cw;
        id_ex.pc       <= i_pc;
        id_ex.rs1_data <= rs1_data;
        id_ex.rs2_data <= rs2_data;
        id_ex.imm      <= imm;
        id_ex.rd       <= ir.r.rd;
    end

endmodule

//--- execute_stage.sv
module execute_stage import rv32i_pkg::*, ctrl_pkg::*; (
    input  logic      clk,
    input  logic      i_rst_n,
    id_ex_if.slave    id_ex,
    ex_mem_if.master  ex_mem,
    output logic      o_redirect,
    output rv32i_word o_target
);

    rv32i_word alu_a;
    rv32i_word alu_b;
    rv32i_word alu_out;
    rv32i_word result;
    logic      br_en;
    logic      taken;

    assign alu_a = (id_ex.cw.alumux1 == am1_pc)  ? id_ex.pc  : id_ex.rs1_data;
    assign alu_b = (id_ex.cw.alumux2 == am2_imm) ? id_ex.imm : id_ex.rs2_data;

    always_comb begin
        case (id_ex.cw.alu_op)
            alu_sub: alu_out = alu_a - alu_b;
            alu_sll: alu_out = alu_a << alu_b[4:0];
            alu_xor: alu_out = alu_a ^ alu_b;
            alu_srl: alu_out = alu_a >> alu_b[4:0];
            alu_sra: alu_out = $signed(alu_a) >>> alu_b[4:0];
            alu_or:  alu_out = alu_a | alu_b;
            alu_and: alu_out = alu_a & alu_b;
            default: alu_out = alu_a + alu_b;
        endcase
    end

    // comparator shares operand b with the alu, so slti sees the immediate
    always_comb begin
        case (id_ex.cw.cmp_op)
            cmp_eq:  br_en = (id_ex.rs1_data == alu_b);
            cmp_ne:  br_en = (id_ex.rs1_data != alu_b);
            cmp_lt:  br_en = ($signed(id_ex.rs1_data) <  $signed(alu_b));
            cmp_ge:  br_en = ($signed(id_ex.rs1_data) >= $signed(alu_b));
            cmp_ltu: br_en = (id_ex.rs1_data <  alu_b);
            cmp_geu: br_en = (id_ex.rs1_data >= alu_b);
            default: br_en = 1'b0;
        endcase
    end

    always_comb begin
        case (id_ex.cw.pcsel)
            pc_branch:       taken = br_en;
            pc_jal, pc_jalr: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    assign o_redirect = id_ex.valid && taken;
    assign o_target   = (id_ex.cw.pcsel == pc_jalr) ? {alu_out[31:1], 1'b0}
                                                    : id_ex.pc + id_ex.imm;

    // lui rides the alu result slot
    assign result = (id_ex.cw.wbmux == wb_uimm) ? id_ex.imm : alu_out;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_mem.cw       <= id_ex.cw;
        ex_mem.pc_plus4 <= id_ex.pc + 32'd4;  // link value
        ex_mem.alu_out  <= result;
        ex_mem.br_en    <= br_en;
        ex_mem.rs2_data <= id_ex.rs2_data;
        ex_mem.rd       <= id_ex.rd;
    end

endmodule

//--- memory_stage.sv
module memory_stage import rv32i_pkg::*, ctrl_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,
    ex_mem_if.slave    ex_mem,
    mem_wb_if.master   mem_wb,
    output rv32i_word  o_dmem_addr,
    output rv32i_word  o_dmem_wdata,
    output logic [3:0] o_dmem_wmask,
    output logic       o_dmem_read,
    output logic       o_dmem_write
);

    logic [1:0] offs;

    assign offs = ex_mem.alu_out[1:0];

    // replicate store data over all lanes, the mask picks the lane
    always_comb begin
        case (store_funct3'(ex_mem.cw.funct3))
            sb: begin
                o_dmem_wdata = {4{ex_mem.rs2_data[7:0]}};
                o_dmem_wmask = 4'b0001 << offs;
            end
            sh: begin
                o_dmem_wdata = {2{ex_mem.rs2_data[15:0]}};
                o_dmem_wmask = 4'b0011 << {offs[1], 1'b0};
            end
            default: begin
                o_dmem_wdata = ex_mem.rs2_data;
                o_dmem_wmask = 4'b1111;
            end
        endcase
    end

    assign o_dmem_addr  = {ex_mem.alu_out[31:2], 2'b00};  // word aligned
    assign o_dmem_read  = ex_mem.valid && ex_mem.cw.load;
    assign o_dmem_write = ex_mem.valid && ex_mem.cw.store;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid <= ex_mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb.cw       <= ex_mem.cw;
        mem_wb.pc_plus4 <= ex_mem.pc_plus4;
        mem_wb.alu_out  <= ex_mem.alu_out;
        mem_wb.br_en    <= ex_mem.br_en;
        mem_wb.rd       <= ex_mem.rd;
        mem_wb.addr_lo  <= offs;
    end

endmodule

//--- writeback_stage.sv
module writeback_stage import rv32i_pkg::*, ctrl_pkg::*; (
    mem_wb_if.slave   mem_wb,
    input  rv32i_word i_dmem_rdata,
    output logic      o_wb_we,
    output rv32i_reg  o_wb_rd,
    output rv32i_word o_wb_data
);

    rv32i_word shifted;    // addressed byte or half moved to bit 0
    rv32i_word load_data;

    assign shifted = i_dmem_rdata >> {mem_wb.addr_lo, 3'b000};

    always_comb begin
        case (load_funct3'(mem_wb.cw.funct3))
            lb:      load_data = {{24{shifted[7]}}, shifted[7:0]};
            lbu:     load_data = {24'h0, shifted[7:0]};
            lh:      load_data = {{16{shifted[15]}}, shifted[15:0]};
            lhu:     load_data = {16'h0, shifted[15:0]};
            default: load_data = i_dmem_rdata;
        endcase
    end

    always_comb begin
        case (mem_wb.cw.wbmux)
            wb_load: o_wb_data = load_data;
            wb_pc4:  o_wb_data = mem_wb.pc_plus4;
            wb_cmp:  o_wb_data = {31'h0, mem_wb.br_en};
            default: o_wb_data = mem_wb.alu_out;  // alu and u immediate
        endcase
    end

    assign o_wb_rd = mem_wb.rd;
    assign o_wb_we = mem_wb.valid && mem_wb.cw.reg_write && (mem_wb.rd != '0);

endmodule

//--- rv32i_pipeline.sv
module rv32i_pipeline import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       i_rst_n,

    output rv32i_word  o_imem_addr,
    output logic       o_imem_read,
    input  rv32i_word  i_imem_rdata,

    output rv32i_word  o_dmem_addr,
    output rv32i_word  o_dmem_wdata,
    output logic [3:0] o_dmem_wmask,
    output logic       o_dmem_read,
    output logic       o_dmem_write,
    input  rv32i_word  i_dmem_rdata
);

    rv32i_word pc_if;
    logic      redirect;
    rv32i_word target;
    logic      wb_we;
    rv32i_reg  wb_rd;
    rv32i_word wb_data;

    id_ex_if  id_ex ();
    ex_mem_if ex_mem ();
    mem_wb_if mem_wb ();

    fetch_stage u_fetch (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_redirect  (redirect),
        .i_target    (target),
        .o_pc        (pc_if),
        .o_imem_addr (o_imem_addr),
        .o_imem_read (o_imem_read)
    );

    decode_stage u_decode (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_instr   (i_imem_rdata),
        .i_pc      (pc_if),
        .i_flush   (redirect),  // squash the two younger slots
        .i_wb_we   (wb_we),
        .i_wb_rd   (wb_rd),
        .i_wb_data (wb_data),
        .id_ex     (id_ex.master)
    );

    execute_stage u_execute (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .id_ex      (id_ex.slave),
        .ex_mem     (ex_mem.master),
        .o_redirect (redirect),
        .o_target   (target)
    );

    memory_stage u_memory (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .ex_mem       (ex_mem.slave),
        .mem_wb       (mem_wb.master),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_wdata (o_dmem_wdata),
        .o_dmem_wmask (o_dmem_wmask),
        .o_dmem_read  (o_dmem_read),
        .o_dmem_write (o_dmem_write)
    );

    writeback_stage u_writeback (
        .mem_wb       (mem_wb.slave),
        .i_dmem_rdata (i_dmem_rdata),
        .o_wb_we      (wb_we),
        .o_wb_rd      (wb_rd),
        .o_wb_data    (wb_data)
    );

endmodule

//--- tb_rv32i_pipeline.sv
module tb_rv32i_pipeline;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [6:0] OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_LD  = 7'b0000011;
    localparam logic [31:0] NOP   = 32'h0000_0013;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
    logic [3:0]  dmem_wmask;
    logic        imem_read, dmem_read, dmem_write;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] ref_mem [256];  // copy of the random fill
    logic [31:0] xr [32];        // expected architectural registers

    // program table, one row per instruction
    logic [31:0] prog [256];
    logic        is_st [256];
    logic        is_ld [256];
    logic [31:0] row_addr [256];  // word address of the access
    logic [3:0]  row_mask [256];
    logic [31:0] row_data [256];
    int          n = 0;
    int          first_st = -1;
    logic [31:0] slot = 32'h100;

    logic [31:0] exp_addr [$];
    logic [3:0]  exp_mask [$];
    logic [31:0] exp_data [$];
    logic [31:0] ld_addr [$];
    int          ei = 0;
    int          li = 0;
    int          errors = 0;
    int          cyc = 0;
    logic        done = 1'b0;

    rv32i_pipeline dut0 (
        .clk          (clk),
        .i_rst_n      (rst_n),
        .o_imem_addr  (imem_addr),
        .o_imem_read  (imem_read),
        .i_imem_rdata (imem_rdata),
        .o_dmem_addr  (dmem_addr),
        .o_dmem_wdata (dmem_wdata),
        .o_dmem_wmask (dmem_wmask),
        .o_dmem_read  (dmem_read),
        .o_dmem_write (dmem_write),
        .i_dmem_rdata (dmem_rdata)
    );

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] op);
        return {12'(imm), 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_s(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), f3, v[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input int imm, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        logic [12:0] v;
        v = 13'(imm);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_u(input int imm, input int rd, input logic [6:0] op);
        return {20'(imm), 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_j(input int imm, input int rd);
        logic [20:0] v;
        v = 21'(imm);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic put(input logic [31:0] w);
        prog[n]  = w;
        is_st[n] = 1'b0;
        is_ld[n] = 1'b0;
        n++;
    endtask

    task automatic put_load(input logic [31:0] w, input logic [31:0] a);
        prog[n]     = w;
        is_st[n]    = 1'b0;
        is_ld[n]    = 1'b1;
        row_addr[n] = a;
        n++;
    endtask

    task automatic put_store(input logic [31:0] w, input logic [31:0] a, input logic [3:0] m,
                             input logic [31:0] d);
        if (first_st < 0) first_st = n;
        prog[n]     = w;
        is_st[n]    = 1'b1;
        is_ld[n]    = 1'b0;
        row_addr[n] = a;
        row_mask[n] = m;
        row_data[n] = d;
        n++;
    endtask

    task automatic pad(input int k);
        repeat (k) put(NOP);
    endtask

    task automatic save_reg(input int rs);
        put_store(enc_s(int'(slot), rs, 0, 3'b010), slot, 4'hf, xr[rs]);
        slot = slot + 32'd4;
    endtask

    // store that only runs if a squash fails
    task automatic marker();
        put(enc_s(12'h3f0, 7, 0, 3'b010));
    endtask

    task automatic branch(input logic [2:0] f3, input int rs1, input int rs2, input logic taken);
        put(enc_b(12, rs2, rs1, f3));  // target skips two slots
        if (taken) begin
            marker();
            marker();
        end else begin
            save_reg(1);
            save_reg(2);
        end
        save_reg(5);
    endtask

    task automatic build_program();
        logic [31:0] w4;
        int          t;
        put(enc_i(12'h123, 0, 0, 1, OP_IMM));
        xr[1] = 32'h123;
        put(enc_i(-5, 0, 0, 2, OP_IMM));
        xr[2] = 32'hffff_fffb;
        put(enc_u(20'habcde, 3, 7'b0110111));
        xr[3] = 32'habcd_e000;
        xr[4] = 32'(n * 4) + 32'h12000;      // auipc adds its own pc
        put(enc_u(20'h00012, 4, 7'b0010111));
        pad(2);
        put(enc_r(7'h00, 2, 1, 3'd0, 5));
        xr[5] = xr[1] + xr[2];
        put(enc_r(7'h20, 2, 1, 3'd0, 6));
        xr[6] = xr[1] - xr[2];
        put(enc_r(7'h00, 1, 3, 3'd4, 7));
        xr[7] = xr[3] ^ xr[1];
        put(enc_r(7'h00, 1, 2, 3'd6, 8));
        xr[8] = xr[2] | xr[1];
        put(enc_r(7'h00, 2, 3, 3'd7, 9));
        xr[9] = xr[3] & xr[2];
        put(enc_r(7'h00, 2, 1, 3'd1, 10));
        xr[10] = xr[1] << xr[2][4:0];
        put(enc_r(7'h20, 1, 3, 3'd5, 11));
        xr[11] = $signed(xr[3]) >>> xr[1][4:0];
        put(enc_i(8, 3, 3'd5, 12, OP_IMM));
        xr[12] = xr[3] >> 8;
        put(enc_i(12'h40c, 3, 3'd5, 13, OP_IMM));
        xr[13] = $signed(xr[3]) >>> 12;
        put(enc_r(7'h00, 1, 2, 3'd2, 14));
        xr[14] = {31'h0, $signed(xr[2]) < $signed(xr[1])};
        put(enc_r(7'h00, 1, 2, 3'd3, 15));
        xr[15] = {31'h0, xr[2] < xr[1]};
        put(enc_i(-3, 2, 3'd2, 16, OP_IMM));
        xr[16] = {31'h0, $signed(xr[2]) < -3};
        put(enc_i(12'h200, 1, 3'd3, 17, OP_IMM));
        xr[17] = {31'h0, xr[1] < 32'h200};
        put(enc_i(-1, 1, 3'd4, 18, OP_IMM));
        xr[18] = ~xr[1];
        put(enc_i(12'h7ff, 3, 3'd6, 19, OP_IMM));
        xr[19] = xr[3] | 32'h7ff;
        put(enc_i(12'h0f0, 2, 3'd7, 20, OP_IMM));
        xr[20] = xr[2] & 32'h0f0;
        put(enc_i(20, 1, 3'd1, 21, OP_IMM));
        xr[21] = xr[1] << 20;
        pad(2);
        for (int r = 1; r <= 21; r++) save_reg(r);
        // sub-word loads from the random word at 0x10
        w4 = ref_mem[4];
        put_load(enc_i(12'h11, 0, 3'd0, 22, OP_LD), 32'h10);
        xr[22] = {{24{w4[15]}}, w4[15:8]};
        put_load(enc_i(12'h13, 0, 3'd4, 23, OP_LD), 32'h10);
        xr[23] = {24'h0, w4[31:24]};
        put_load(enc_i(12'h12, 0, 3'd1, 24, OP_LD), 32'h10);
        xr[24] = {{16{w4[31]}}, w4[31:16]};
        put_load(enc_i(12'h10, 0, 3'd5, 25, OP_LD), 32'h10);
        xr[25] = {16'h0, w4[15:0]};
        put_load(enc_i(12'h14, 0, 3'd2, 26, OP_LD), 32'h14);
        xr[26] = ref_mem[5];
        put_load(enc_i(12'h10, 0, 3'd0, 27, OP_LD), 32'h10);
        xr[27] = {{24{w4[7]}}, w4[7:0]};
        pad(2);
        for (int r = 22; r <= 27; r++) save_reg(r);
        // sb and sh, one lane per mask bit
        put_store(enc_s(12'h201, 1, 0, 3'd0), 32'h200, 4'b0010, {4{xr[1][7:0]}});
        put_store(enc_s(12'h206, 3, 0, 3'd1), 32'h204, 4'b1100, {2{xr[3][15:0]}});
        put_store(enc_s(12'h20b, 7, 0, 3'd0), 32'h208, 4'b1000, {4{xr[7][7:0]}});
        put_store(enc_s(12'h20c, 2, 0, 3'd1), 32'h20c, 4'b0011, {2{xr[2][15:0]}});
        branch(3'd0, 1, 1, xr[1] == xr[1]);
        branch(3'd1, 1, 1, xr[1] != xr[1]);
        branch(3'd4, 2, 1, $signed(xr[2]) < $signed(xr[1]));
        branch(3'd5, 2, 1, $signed(xr[2]) >= $signed(xr[1]));
        branch(3'd6, 1, 2, xr[1] < xr[2]);
        branch(3'd7, 1, 2, xr[1] >= xr[2]);
        xr[28] = 32'(n * 4 + 4);  // jal link
        put(enc_j(12, 28));
        marker();
        marker();
        save_reg(5);
        save_reg(28);
        t = (n + 6) * 4;          // jalr target, bit 0 set in the offset
        put(enc_i(t, 0, 3'd0, 29, OP_IMM));
        pad(2);
        xr[30] = 32'(n * 4 + 4);
        put(enc_i(1, 29, 3'd0, 30, 7'b1100111));
        marker();
        marker();
        save_reg(5);
        save_reg(30);
        put(enc_i(12'h55, 0, 3'd0, 0, OP_IMM));  // write to x0 is dropped
        pad(2);
        save_reg(0);
        put(enc_u(1, 31, 7'b0110111));
        pad(2);
        put_store(enc_s(-4, 0, 31, 3'd2), 32'hffc, 4'hf, 32'h0);  // end of run
        pad(4);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory models, read data one cycle after the address
    always @(posedge clk) begin
        imem_rdata <= imem[imem_addr[9:2]];
        dmem_rdata <= dmem[dmem_addr[9:2]];
        if (dmem_write) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_wmask[b]) dmem[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) cyc <= cyc + 1;
    end

    // fetch port, first address after reset and a request every cycle
    always @(posedge clk) begin
        if (rst_n) begin
            assert (imem_read) else begin
                errors++;
                $display("[FAIL] o_imem_read got %h expected %h", imem_read, 1'b1);
            end
        end
        if (rst_n && cyc == 0) begin
            assert (imem_addr == 32'h0) else begin
                errors++;
                $display("[FAIL] o_imem_addr got %h expected %h", imem_addr, 32'h0);
            end
        end
    end

    // load monitor
    always @(posedge clk) begin
        if (rst_n && dmem_read && !done) begin
            assert (li < ld_addr.size()) else begin
                errors++;
                $display("load strobe seen after the last expected load");
            end
            if (li < ld_addr.size()) begin
                assert (dmem_addr == ld_addr[li]) else begin
                    errors++;
                    $display("[FAIL] o_dmem_addr got %h expected %h", dmem_addr, ld_addr[li]);
                end
                li <= li + 1;
            end
        end
    end

    // store monitor
    always @(posedge clk) begin
        if (cyc < first_st + 3) begin
            assert (!dmem_write) else begin
                errors++;
                $display("store strobe seen before the first store reached memory");
            end
        end
        if (rst_n && dmem_write && !done) begin
            assert (ei < exp_addr.size()) else begin
                errors++;
                $display("store seen after the last expected store");
            end
            if (ei < exp_addr.size()) begin
                assert (dmem_addr == exp_addr[ei]) else begin
                    errors++;
                    $display("[FAIL] o_dmem_addr got %h expected %h", dmem_addr, exp_addr[ei]);
                end
                assert (dmem_wmask == exp_mask[ei]) else begin
                    errors++;
                    $display("[FAIL] o_dmem_wmask got %h expected %h", dmem_wmask, exp_mask[ei]);
                end
                assert (dmem_wdata == exp_data[ei]) else begin
                    errors++;
                    $display("[FAIL] o_dmem_wdata got %h expected %h", dmem_wdata, exp_data[ei]);
                end
                ei <= ei + 1;
            end
            if (dmem_addr == 32'hffc) done <= 1'b1;
        end
    end

    initial begin
        int limit;
        rst_n      = 1'b0;
        imem_rdata = NOP;
        dmem_rdata = 32'h0;
        for (int i = 0; i < 32; i++) xr[i] = 32'h0;
        void'($urandom(32'hf2a6_599d));
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = $urandom;
            dmem[i]    = ref_mem[i];
            imem[i]    = NOP;
        end
        build_program();
        for (int i = 0; i < n; i++) begin  // load the table
            imem[i] = prog[i];
            if (is_st[i]) begin
                exp_addr.push_back(row_addr[i]);
                exp_mask.push_back(row_mask[i]);
                exp_data.push_back(row_data[i]);
            end
            if (is_ld[i]) begin
                ld_addr.push_back(row_addr[i]);
            end
        end
        limit = 4 * n + 50;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        while (!done && cyc < limit) @(posedge clk);
        @(posedge clk);
        if (!done) begin
            errors++;
            $display("timeout after %0d cycles without the final store", cyc);
        end
        assert (ei == exp_addr.size()) else begin
            errors++;
            $display("only %0d of %0d expected stores were seen", ei, exp_addr.size());
        end
        assert (li == ld_addr.size()) else begin
            errors++;
            $display("only %0d of %0d expected loads were seen", li, ld_addr.size());
        end
        $display("stores checked %0d, loads checked %0d, errors %0d", ei, li, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
rv32i_pkg.sv
ctrl_pkg.sv
stage_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
writeback_stage.sv
rv32i_pipeline.sv
tb_rv32i_pipeline.sv

//--- Makefile
TB = tb_rv32i_pipeline

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module rv32i_pipeline

sim:
	verilator --binary --timing -f compile.f --top-module $(TB) -o sim_$(TB)
	./obj_dir/sim_$(TB) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
